/* Bender.yml */
package:
  name: obj_line_engine

sources:
  - source/obj_pkg.sv
  - source/vram_arbiter.sv
  - source/obj_row_scanner.sv
  - source/obj_pixel_fetcher.sv
  - source/obj_line_buffer.sv
  - source/obj_line_engine.sv
  - target: test
    files:
      - bench/obj_line_engine_props.sv
      - bench/obj_line_engine_tb.sv

/* bench/obj_line_engine_props.sv */
`timescale 1ns/1ns

module obj_line_engine_props (
    input logic              clock,
    input logic              reset,
    input logic              start,
    input logic              busy,
    input logic              done,
    input obj_pkg::mem_req_t mem_req
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Completion strobe
    done_single_cycle: assert property (
        @(posedge clock) disable iff (!reset) done |=> !done
    ) else $error("done stayed high for more than one cycle");

    busy_after_done: assert property (
        @(posedge clock) disable iff (!reset) done |=> !busy
    ) else $error("busy still high in the cycle after done");

    // Memory stays quiet between lines.
    read_only_when_busy: assert property (
        @(posedge clock) disable iff (!reset) (mem_req.read && !busy) |-> $past(start)
    ) else $error("memory read issued while the engine was idle");

endmodule

bind obj_line_engine obj_line_engine_props obj_line_engine_props_i (
    .clock(clock), .reset(reset), .start(start),
    .busy(busy), .done(done), .mem_req(mem_req)
);

/* bench/obj_line_engine_tb.sv */
`timescale 1ns/1ns

module obj_line_engine_tb;
    import obj_pkg::*;

    localparam int    MAX_TESTS     = 8;
    localparam int    MEM_WORDS     = 4096;
    localparam int    DONE_TIMEOUT  = 4000;   // Cycles allowed for one line.
    localparam int    IDLE_TIMEOUT  = 100;
    localparam string STIMULUS_FILE = "bench/obj_stimulus.txt";

    logic       clock;
    logic       reset;
    logic       start;
    logic [7:0] row;
    logic       busy;
    logic       done;
    mem_req_t   mem_req;
    mem_word_t  mem_rdata;
    logic [5:0] read_x;
    pixel_out_t pixel;

    mem_word_t  memory [MEM_WORDS];
    string      test_name [MAX_TESTS];
    logic [7:0] test_row [MAX_TESTS];
    pixel_out_t expected [MAX_TESTS][LINE_WIDTH];
    int         test_count;
    int         check_count;
    int         error_count;

    obj_line_engine #(.OBJ_COUNT(16), .MAX_VISIBLE(4)) obj_line_engine_i (
        .clock(clock), .reset(reset), .start(start), .row(row),
        .busy(busy), .done(done), .mem_req(mem_req), .mem_rdata(mem_rdata),
        .read_x(read_x), .pixel(pixel)
    );

    always #2 clock = ~clock;

    // Memory model with one cycle of read latency.
    always @(posedge clock) begin
        if (mem_req.read) begin
            mem_rdata <= memory[mem_req.addr];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus file parsing
    task automatic load_stimulus();
        int        fd;
        int        fields;
        int        addr;
        int        x;
        int        index;
        int        row_value;
        mem_word_t data;
        string     line;
        string     kind;
        string     name;
        fd = $fopen(STIMULUS_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIMULUS_FILE);
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s", kind);
                if (fields == 1 && kind == "M") begin
                    fields = $sscanf(line, "%s %h %h", kind, addr, data);
                    memory[addr] = data;
                end else if (fields == 1 && kind == "R") begin
                    fields = $sscanf(line, "%s %s %d", kind, name, row_value);
                    if (test_count == MAX_TESTS) begin
                        $display("Too many tests in the stimulus file, %s dropped", name);
                        error_count++;
                    end else begin
                        test_name[test_count] = name;
                        test_row[test_count]  = row_value[7:0];
                        for (int i = 0; i < LINE_WIDTH; i++) begin
                            expected[test_count][i] = '0;   // Transparent.
                        end
                        test_count++;
                    end
                end else if (fields == 1 && kind == "E") begin
                    fields = $sscanf(line, "%s %d %h", kind, x, index);
                    if (test_count == 0 || x < 0 || x >= LINE_WIDTH) begin
                        $display("Expected pixel line is out of place or out of range");
                        error_count++;
                    end else begin
                        expected[test_count-1][x].opaque = 1'b1;
                        expected[test_count-1][x].index  = index[7:0];
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line rendering and pixel checks
    task automatic render_line(input int t, output logic finished);
        int cycles;
        cycles = 0;
        while (busy && cycles < IDLE_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (busy) begin
            $display("Engine still busy before test %s could start", test_name[t]);
            error_count++;
        end
        @(negedge clock);
        row   = test_row[t];
        start = 1'b1;
        @(negedge clock);
        start  = 1'b0;
        if (!busy) begin
            $display("Engine did not raise busy after start in test %s", test_name[t]);
            error_count++;
        end
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        finished = done;
        if (!done) begin
            $display("Test %s timed out, no done within %0d cycles", test_name[t], cycles);
        end
    endtask

    task automatic compare_pixels(input int t);
        pixel_out_t want;
        for (int x = 0; x < LINE_WIDTH; x++) begin
            @(negedge clock);
            read_x = x[5:0];
            @(negedge clock);                // Registered read port.
            want = expected[t][x];
            check_count++;
            if (pixel.opaque !== want.opaque ||
                (want.opaque && pixel.index !== want.index)) begin
                error_count++;
                $display("ERROR %s x=%0d expected=%03h actual=%03h",
                         test_name[t], x, want, pixel);
            end
        end
    endtask

    initial begin
        logic finished;
        clock       = 1'b0;
        reset       = 1'b0;
        start       = 1'b0;
        row         = '0;
        read_x      = '0;
        mem_rdata   = '0;
        test_count  = 0;
        check_count = 0;
        error_count = 0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            memory[a] = '0;
        end
        load_stimulus();
        repeat (3) @(negedge clock);
        reset = 1'b1;
        if (test_count == 0) begin
            $display("No tests were found in the stimulus file");
            error_count++;
        end
        for (int t = 0; t < test_count; t++) begin
            render_line(t, finished);
            if (finished) begin
                compare_pixels(t);
            end else begin
                error_count++;
            end
        end
        $display("Tests: %0d, pixel checks: %0d, errors: %0d",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/obj_stimulus.txt */
# M <word address hex> <data hex>, R <test name> <row decimal>
# E <x decimal> <index hex> for the last R line; unlisted x is transparent
M 000 14108004
M 001 28C06005
M 002 FA2B8406
M 003 3C788010
M 004 3C808011
M 005 50F18012
M 006 50000813
M 007 50201013
M 008 50401813
M 009 50602013
M 00A 50A02813
M 00B C0000000
M 00C C0000000
M 00D C0000000
M 00E C0000000
M 00F C0000000
M 020 84008281
M 021 88000000
M 022 00930000
M 028 07B0003A
M 04C 00003300
M 04F AA000000
M 050 000000EE
M 080 12110000
M 081 00001500
M 088 24232221
M 090 64636261
M 091 70707070
M 098 00000005
R single_8bpp 20
E 4 81
E 5 82
E 7 84
E 11 88
R second_row 21
E 6 93
R nibble_4bpp 40
E 48 CA
E 49 C3
E 53 CB
E 54 C7
R flip_wrap 2
E 11 33
E 25 AA
R overlap 60
E 32 11
E 33 12
E 34 23
E 35 15
R limit_edge 80
E 0 15
E 8 25
E 16 35
E 60 61
E 61 62
E 62 63
E 63 64

/* build.f */
source/obj_pkg.sv
source/vram_arbiter.sv
source/obj_row_scanner.sv
source/obj_pixel_fetcher.sv
source/obj_line_buffer.sv
source/obj_line_engine.sv
bench/obj_line_engine_props.sv
bench/obj_line_engine_tb.sv

/* source/obj_line_buffer.sv */
`timescale 1ns/1ns

module obj_line_buffer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  obj_pkg::pixel_write_t pixel_write,
    input  logic [5:0]            read_x,
    output obj_pkg::pixel_out_t   pixel
);
    import obj_pkg::*;

    logic [7:0]            index_mem [LINE_WIDTH];
    logic [LINE_WIDTH-1:0] occupied;
    logic                  accept;

    // First writer wins, so lower object indices have priority.
    assign accept = pixel_write.write && !occupied[pixel_write.x] && !start;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            occupied <= '0;
        end else if (start) begin
            occupied <= '0;                  // Whole line cleared at once.
        end else if (accept) begin
            occupied[pixel_write.x] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            index_mem[pixel_write.x] <= pixel_write.index;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered read port
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pixel <= '0;
        end else begin
            pixel.opaque <= occupied[read_x];
            pixel.index  <= occupied[read_x] ? index_mem[read_x] : 8'h00;
        end
    end

endmodule

/* source/obj_line_engine.sv */
`timescale 1ns/1ns

module obj_line_engine #(
    parameter int OBJ_COUNT   = 16,
    parameter int MAX_VISIBLE = 4
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  logic [7:0]          row,
    output logic                busy,
    output logic                done,
    output obj_pkg::mem_req_t   mem_req,
    input  obj_pkg::mem_word_t  mem_rdata,
    input  logic [5:0]          read_x,
    output obj_pkg::pixel_out_t pixel
);
    import obj_pkg::*;

    mem_req_t     scan_req;
    mem_req_t     fetch_req;
    logic         scan_grant;
    logic         fetch_grant;
    logic         scan_rdata_valid;
    logic         fetch_rdata_valid;
    mem_word_t    rdata;
    logic         pop;
    logic         queue_empty;
    logic         scan_done;
    obj_attr_t    head;
    pixel_write_t pixel_write;
    logic         start_accept;

    assign start_accept = start && !busy;    // Ignored while a line is in progress.

    vram_arbiter vram_arbiter_i (
        .clock(clock), .reset(reset),
        .scan_req(scan_req), .fetch_req(fetch_req),
        .scan_grant(scan_grant), .fetch_grant(fetch_grant),
        .scan_rdata_valid(scan_rdata_valid), .fetch_rdata_valid(fetch_rdata_valid),
        .rdata(rdata), .mem_req(mem_req), .mem_rdata(mem_rdata)
    );

    obj_row_scanner #(.OBJ_COUNT(OBJ_COUNT), .MAX_VISIBLE(MAX_VISIBLE)) obj_row_scanner_i (
        .clock(clock), .reset(reset), .start(start_accept), .row(row),
        .mem_req(scan_req), .grant(scan_grant), .rdata_valid(scan_rdata_valid),
        .rdata(rdata), .pop(pop), .queue_empty(queue_empty),
        .scan_done(scan_done), .head(head)
    );

    obj_pixel_fetcher obj_pixel_fetcher_i (
        .clock(clock), .reset(reset), .start(start_accept), .row(row),
        .queue_empty(queue_empty), .scan_done(scan_done), .head(head), .pop(pop),
        .mem_req(fetch_req), .grant(fetch_grant), .rdata_valid(fetch_rdata_valid),
        .rdata(rdata), .pixel_write(pixel_write), .busy(busy), .done(done)
    );

    obj_line_buffer obj_line_buffer_i (
        .clock(clock), .reset(reset), .start(start_accept),
        .pixel_write(pixel_write), .read_x(read_x), .pixel(pixel)
    );

endmodule

/* source/obj_pixel_fetcher.sv */
`timescale 1ns/1ns

module obj_pixel_fetcher (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  logic [7:0]           row,
    input  logic                 queue_empty,
    input  logic                 scan_done,
    input  obj_pkg::obj_attr_t   head,
    output logic                 pop,
    output obj_pkg::mem_req_t    mem_req,
    input  logic                 grant,
    input  logic                 rdata_valid,
    input  obj_pkg::mem_word_t   rdata,
    output obj_pkg::pixel_write_t pixel_write,
    output logic                 busy,
    output logic                 done
);
    import obj_pkg::*;

    typedef enum logic [2:0] {IDLE, LOAD, REQUEST, WAIT, NEXT} state_t;

    state_t      state;
    obj_attr_t   obj;
    logic [3:0]  col;
    logic [3:0]  local_row;
    logic [7:0]  row_q;
    logic [7:0]  head_offset;
    logic [4:0]  flip_row;
    logic [4:0]  obj_w;
    logic [7:0]  pixel_num;
    logic [7:0]  byte_offset;
    logic [14:0] byte_addr;
    logic [7:0]  data_byte;
    logic [3:0]  nibble;
    logic        opaque;
    logic [6:0]  screen_x;
    logic        last_col;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Local row of the head object
    assign head_offset = row_q - head.objy;
    assign flip_row    = obj_height(head.size) - 5'd1 - {1'b0, head_offset[3:0]};
    assign pop         = (state == LOAD) && !queue_empty;

    always_ff @(posedge clock) begin
        if (start) begin
            row_q <= row;
        end
        if (pop) begin
            obj       <= head;
            local_row <= head.flip ? flip_row[3:0] : head_offset[3:0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address and pixel extraction
    assign obj_w       = obj_width(obj.size);
    assign pixel_num   = obj_w[4] ? {local_row, col} : {1'b0, local_row, col[2:0]};
    assign byte_offset = obj.palettemode ? pixel_num : {1'b0, pixel_num[7:1]};
    assign byte_addr   = {obj.tile_base, 5'b00000} + {7'b0000000, byte_offset};
    assign data_byte   = rdata[byte_addr[1:0]*8 +: 8];    // Lowest byte first.
    assign nibble      = col[0] ? data_byte[7:4] : data_byte[3:0];
    assign opaque      = obj.palettemode ? (data_byte != 8'h00) : (nibble != 4'h0);
    assign screen_x    = {1'b0, obj.objx} + {3'b000, col};
    assign last_col    = (col == 4'(obj_w - 5'd1));

    always_comb begin
        mem_req.read      = (state == REQUEST);
        mem_req.addr      = byte_addr[MEM_ADDR_WIDTH+1:2];
        pixel_write.write = (state == WAIT) && rdata_valid && opaque &&
                            (screen_x < 7'(LINE_WIDTH));  // No wrap at the edge.
        pixel_write.x     = screen_x[5:0];
        pixel_write.index = obj.palettemode ? data_byte : {obj.paletteno, nibble};
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
            col   <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (done) begin
                busy <= 1'b0;                // Drops after the done cycle.
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        busy  <= 1'b1;
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    if (!queue_empty) begin
                        col   <= '0;
                        state <= REQUEST;
                    end else if (scan_done) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                REQUEST: begin
                    if (grant) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (rdata_valid) begin
                        state <= NEXT;
                    end
                end
                NEXT: begin
                    if (last_col) begin
                        state <= LOAD;
                    end else begin
                        col   <= col + 1'b1;
                        state <= REQUEST;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* source/obj_pkg.sv */
package obj_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line and memory geometry
    localparam int LINE_WIDTH     = 64;
    localparam int MEM_ADDR_WIDTH = 12;

    typedef logic [31:0] mem_word_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Object attributes
    typedef enum logic [1:0] {
        SIZE_8X8   = 2'b00,
        SIZE_16X8  = 2'b01,                  // Bit 0 selects width 16.
        SIZE_8X16  = 2'b10,                  // Bit 1 selects height 16.
        SIZE_16X16 = 2'b11
    } obj_size_t;

    typedef struct packed {
        logic [7:0] objy;
        logic [5:0] objx;
        obj_size_t  size;
        logic       palettemode;             // 1 is 8 bits per pixel.
        logic [3:0] paletteno;
        logic       flip;                    // Vertical flip.
        logic [9:0] tile_base;               // In units of 32 bytes.
    } obj_attr_t;

    function automatic logic [4:0] obj_height(input obj_size_t size);
        return size[1] ? 5'd16 : 5'd8;
    endfunction

    function automatic logic [4:0] obj_width(input obj_size_t size);
        return size[0] ? 5'd16 : 5'd8;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory port and line buffer traffic
    typedef struct packed {
        logic                      read;
        logic [MEM_ADDR_WIDTH-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic       write;
        logic [5:0] x;
        logic [7:0] index;
    } pixel_write_t;

    typedef struct packed {
        logic       opaque;
        logic [7:0] index;
    } pixel_out_t;

endpackage

/* source/obj_row_scanner.sv */
`timescale 1ns/1ns

module obj_row_scanner #(
    parameter int OBJ_COUNT   = 16,
    parameter int MAX_VISIBLE = 4
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               start,
    input  logic [7:0]         row,
    output obj_pkg::mem_req_t  mem_req,
    input  logic               grant,
    input  logic               rdata_valid,
    input  obj_pkg::mem_word_t rdata,
    input  logic               pop,
    output logic               queue_empty,
    output logic               scan_done,
    output obj_pkg::obj_attr_t head
);
    import obj_pkg::*;

    localparam int IDX_W = (OBJ_COUNT > 1) ? $clog2(OBJ_COUNT) : 1;
    localparam int PTR_W = (MAX_VISIBLE > 1) ? $clog2(MAX_VISIBLE) : 1;
    localparam int CNT_W = $clog2(MAX_VISIBLE + 1);

    typedef enum logic [1:0] {IDLE, REQUEST, WAIT, DONE} state_t;

    state_t           state;
    logic [IDX_W-1:0] index;
    logic [CNT_W-1:0] found;
    logic [7:0]       row_q;
    obj_attr_t        attr;
    logic [7:0]       row_offset;
    logic             visible;
    logic             push;
    logic             last_entry;
    obj_attr_t        queue [MAX_VISIBLE];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(MAX_VISIBLE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Visibility test on the returned attribute word
    assign attr       = rdata;
    assign row_offset = row_q - attr.objy;   // Wraps modulo 256.
    assign visible    = row_offset < {3'b000, obj_height(attr.size)};
    assign push       = (state == WAIT) && rdata_valid && visible;
    assign last_entry = (index == IDX_W'(OBJ_COUNT - 1)) ||
                        (push && (found == CNT_W'(MAX_VISIBLE - 1)));

    always_ff @(posedge clock) begin
        if (start) begin
            row_q <= row;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
            index <= '0;
            found <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        index <= '0;
                        found <= '0;
                        state <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (grant) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (rdata_valid) begin
                        if (push) begin
                            found <= found + 1'b1;
                        end
                        if (last_entry) begin
                            state <= DONE;
                        end else begin
                            index <= index + 1'b1;
                            state <= REQUEST;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        mem_req.read = (state == REQUEST);
        mem_req.addr = MEM_ADDR_WIDTH'(index); // Table starts at word 0.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Visible object FIFO
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (start) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            queue[wr_ptr] <= attr;
        end
    end

    assign head        = queue[rd_ptr];
    assign queue_empty = (count == '0);
    assign scan_done   = (state == DONE);

endmodule

/* source/vram_arbiter.sv */
`timescale 1ns/1ns

module vram_arbiter (
    input  logic               clock,
    input  logic               reset,
    input  obj_pkg::mem_req_t  scan_req,
    input  obj_pkg::mem_req_t  fetch_req,
    output logic               scan_grant,
    output logic               fetch_grant,
    output logic               scan_rdata_valid,
    output logic               fetch_rdata_valid,
    output obj_pkg::mem_word_t rdata,
    output obj_pkg::mem_req_t  mem_req,
    input  obj_pkg::mem_word_t mem_rdata
);

    logic last_fetch;                        // Fetcher won the last grant.
    logic in_flight;                         // Read data returns this cycle.

    // Contention goes to the side not granted last time.
    assign scan_grant  = scan_req.read && (!fetch_req.read || last_fetch);
    assign fetch_grant = fetch_req.read && (!scan_req.read || !last_fetch);

    always_comb begin
        mem_req.read = scan_grant || fetch_grant;
        mem_req.addr = fetch_grant ? fetch_req.addr : scan_req.addr;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            last_fetch <= 1'b0;
            in_flight  <= 1'b0;
        end else begin
            in_flight <= mem_req.read;
            if (mem_req.read) begin
                last_fetch <= fetch_grant;
            end
        end
    end

    // The owner of returning data is always the last grant.
    assign scan_rdata_valid  = in_flight && !last_fetch;
    assign fetch_rdata_valid = in_flight && last_fetch;
    assign rdata             = mem_rdata;

endmodule
